/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module fetch_tb -o fetch_tb_sim
	./obj_dir/fetch_tb_sim | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/fetch_tb.sv */
`timescale 1ns/100ps

`include "fetch_defines.svh"

module fetch_tb;

    logic             CLK;
    logic             nRST;
    logic             load_en;
    fetch_pkg::word_t load_addr;
    fetch_pkg::word_t load_data;
    logic             stall;
    logic             trap_valid;
    fetch_pkg::word_t trap_pc;
    logic             retire_valid;
    fetch_pkg::word_t retire_pc;
    fetch_pkg::word_t retire_instr;
    logic             retire_fault;

    // Program image, plus the JALs the tests placed in it
    fetch_pkg::word_t image    [`IMEM_WORDS];
    logic             jmp_flag [`IMEM_WORDS];
    fetch_pkg::word_t jmp_off  [`IMEM_WORDS];

    logic [31:0]      lfsr;
    // Reference model state
    fetch_pkg::word_t exp_pc;
    int               retired;
    int               checks;
    int               errors;
    string            test_name;

    fetch_top dut (
        .CLK          (CLK),
        .nRST         (nRST),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .stall        (stall),
        .trap_valid   (trap_valid),
        .trap_pc      (trap_pc),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_instr (retire_instr),
        .retire_fault (retire_fault)
    );

    // 100 ns clock
    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic fetch_pkg::word_t rand_word();
        fetch_pkg::word_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], next_bit()};
        end
        return w;
    endfunction

    // J-type encoding, rd = x1
    function automatic fetch_pkg::word_t enc_jal(input fetch_pkg::word_t off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'h6F};
    endfunction

    // Expected word for a PC, zero when misaligned
    function automatic fetch_pkg::word_t model_instr(input fetch_pkg::word_t pc);
        if (pc[1:0] != 2'b00) begin
            return '0;
        end
        return image[pc[9:2]];
    endfunction

    // Program walk, taken JALs follow the placed offset
    function automatic fetch_pkg::word_t model_next(input fetch_pkg::word_t pc);
        if (pc[1:0] == 2'b00 && jmp_flag[pc[9:2]]) begin
            return pc + jmp_off[pc[9:2]];
        end
        return pc + 32'd4;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic end_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    // Inputs change 10 ns after the rising edge
    task automatic step();
        @(posedge CLK);
        #10;
    endtask

    // Retire monitor, checks every retire against the model
    always @(posedge CLK) begin
        if (nRST && retire_valid) begin
            check_value({test_name, " pc"}, exp_pc, retire_pc);
            check_value({test_name, " instr"}, model_instr(exp_pc), retire_instr);
            check_value({test_name, " fault"}, {31'b0, exp_pc[1:0] != 2'b00},
                        {31'b0, retire_fault});
            exp_pc = model_next(exp_pc);
            retired++;
        end
    end

    // Reset first so the monitor stops before the image changes
    task automatic hold_reset(input string name);
        nRST = 1'b0;
        stall = 1'b0;
        trap_valid = 1'b0;
        test_name = name;
        step();
    endtask

    task automatic fill_random();
        fetch_pkg::word_t w;
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            w = rand_word();
            // Only placed JALs may jump
            if (w[6:0] == 7'h6F) begin
                w[6:0] = 7'h13;
            end
            image[i] = w;
            jmp_flag[i] = 1'b0;
            jmp_off[i] = '0;
        end
    endtask

    task automatic place_jal(input fetch_pkg::word_t addr, input fetch_pkg::word_t off);
        image[addr[9:2]] = enc_jal(off);
        jmp_flag[addr[9:2]] = 1'b1;
        jmp_off[addr[9:2]] = off;
    endtask

    // Load under reset, then 10 more reset cycles
    task automatic load_and_start();
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            load_en = 1'b1;
            load_addr = 32'(i * 4);
            load_data = image[i];
            step();
        end
        load_en = 1'b0;
        exp_pc = `FETCH_RESET_PC;
        retired = 0;
        repeat (10) begin
            step();
            check_value({test_name, " reset retire_valid"}, 32'd0, {31'b0, retire_valid});
        end
        nRST = 1'b1;
    endtask

    task automatic wait_retires(input int target);
        int cycles;
        cycles = 0;
        while (retired < target && cycles < 1000) begin
            step();
            cycles++;
        end
        if (retired < target) begin
            $display("Timeout in %s: saw %0d of %0d retires after %0d cycles",
                     test_name, retired, target, cycles);
            errors++;
            end_run();
        end
    endtask

    // Fill the queue under stall, then a one-cycle trap
    task automatic raise_trap(input fetch_pkg::word_t pc);
        stall = 1'b1;
        repeat (10) step();
        // Nothing left to retire, model follows the trap now
        trap_valid = 1'b1;
        trap_pc = pc;
        exp_pc = pc;
        step();
        trap_valid = 1'b0;
        repeat (3) step();
        stall = 1'b0;
    endtask

    task automatic test_straight();
        hold_reset("straight");
        fill_random();
        load_and_start();
        wait_retires(21);
    endtask

    task automatic test_jal();
        hold_reset("jal");
        fill_random();
        // Forward into a loop closed by a backward jump
        place_jal(32'h108, 32'h40);
        place_jal(32'h150, 32'hFFFF_FFD0);
        load_and_start();
        wait_retires(30);
    endtask

    task automatic test_backpressure();
        hold_reset("backpressure");
        fill_random();
        place_jal(32'h140, 32'h80);
        load_and_start();
        for (int i = 0; i < 200; i++) begin
            // Forced runs of 8 outlast the queue depth
            if (i % 50 < 8) begin
                stall = 1'b1;
            end else begin
                stall = next_bit();
            end
            step();
        end
        stall = 1'b0;
        wait_retires(retired + 10);
    endtask

    task automatic test_trap();
        hold_reset("trap");
        fill_random();
        load_and_start();
        wait_retires(8);
        raise_trap(32'h300);
        wait_retires(retired + 12);
    endtask

    task automatic test_misaligned();
        hold_reset("misaligned");
        fill_random();
        // Target lands 2 bytes off a word
        place_jal(32'h104, 32'h22);
        load_and_start();
        wait_retires(6);
        raise_trap(32'h180);
        wait_retires(retired + 6);
        raise_trap(32'h201);
        wait_retires(retired + 6);
        raise_trap(32'h140);
        wait_retires(retired + 8);
    endtask

    initial begin
        nRST = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        stall = 1'b0;
        trap_valid = 1'b0;
        trap_pc = '0;
        lfsr = 32'h7792_4489;
        exp_pc = `FETCH_RESET_PC;
        retired = 0;
        checks = 0;
        errors = 0;
        test_name = "init";
        test_straight();
        test_jal();
        test_backpressure();
        test_trap();
        test_misaligned();
        end_run();
    end

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    head_valid,
    input  fetch_pkg::fetch_entry_t head_entry,
    output logic                    pop,
    input  logic                    stall,
    input  logic                    trap_valid,
    input  fetch_pkg::word_t        trap_pc,
    output logic                    redirect_valid,
    output fetch_pkg::word_t        redirect_pc,
    output logic                    retire_valid,
    output fetch_pkg::word_t        retire_pc,
    output fetch_pkg::word_t        retire_instr,
    output logic                    retire_fault
);
    // RV32 JAL major opcode
    localparam logic [6:0] OPC_JAL = 7'h6F;

    fetch_pkg::word_t instr;
    fetch_pkg::word_t jal_imm;
    fetch_pkg::word_t jal_target;
    logic             is_jal;

    assign instr = head_entry.instr;

    // Take the head whenever allowed
    assign pop = head_valid && !stall;

    // Faulted entries carry a zero word, never a jump
    assign is_jal = pop && !head_entry.fault && (instr[6:0] == OPC_JAL);

    // J-type immediate
    // imm[20|10:1|11|19:12] in bits 31:12, sign extended
    assign jal_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                      instr[30:21], 1'b0};

    assign jal_target = head_entry.pc + jal_imm;

    // Trap takes priority over JAL
    // like a privileged PC insert over a branch
    assign redirect_valid = trap_valid || is_jal;
    assign redirect_pc    = trap_valid ? trap_pc : jal_target;

    // Retire valid
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= pop;
        end
    end

    // Retire payload, loaded on every pop
    // A pop in a redirect cycle still retires
    always_ff @(posedge CLK) begin
        if (pop) begin
            retire_pc    <= head_entry.pc;
            retire_instr <= head_entry.instr;
            retire_fault <= head_entry.fault;
        end
    end

endmodule

/* hw/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Program counter value out of reset
`define FETCH_RESET_PC 32'h0000_0100

// Fetch queue entries
// Also the number of credits fetch starts with
`define FETCH_QUEUE_DEPTH 4

// Instruction memory size in 32-bit words
// Index comes from PC bits 9:2, upper bits wrap
`define IMEM_WORDS 256

// Cycles from read issue to read data
`define IMEM_LATENCY 2

`endif

/* hw/fetch_pkg.sv */
package fetch_pkg;

    // One machine word, used for PCs and instructions
    typedef logic [31:0] word_t;

    // Fetch queue payload
    // instr is forced to zero on a faulted entry
    typedef struct packed {
        word_t pc;
        word_t instr;
        // Misaligned fetch address
        logic  fault;
    } fetch_entry_t;

endpackage

/* hw/fetch_queue.sv */
`timescale 1ns/100ps

`include "fetch_defines.svh"

module fetch_queue #(
    parameter type entry_t = fetch_pkg::fetch_entry_t,
    parameter int  DEPTH   = `FETCH_QUEUE_DEPTH
) (
    input  logic   CLK,
    input  logic   nRST,
    input  logic   push,
    input  entry_t push_entry,
    input  logic   flush,
    output logic   head_valid,
    output entry_t head_entry,
    input  logic   pop,
    output logic   credit_return
);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    entry_t        slots [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
        if (ptr == PW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Flush wins over both push and pop
    assign do_push = push && !flush;
    assign do_pop  = pop && !flush;

    // One credit per pop
    // None on a flush, fetch reloads its counter instead
    assign credit_return = do_pop;

    assign head_valid = (count != '0);
    assign head_entry = slots[rd_ptr];

    // Pointers and fill count
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge CLK) begin
        if (do_push) begin
            slots[wr_ptr] <= push_entry;
        end
    end

    // Credits should make this impossible
    a_no_push_full: assert property (
        @(posedge CLK) disable iff (!nRST) push |-> (count != CW'(DEPTH)))
        else $error("fetch_queue: push into a full queue");

    a_no_pop_empty: assert property (
        @(posedge CLK) disable iff (!nRST) pop |-> (count != '0))
        else $error("fetch_queue: pop from an empty queue");

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/100ps

`include "fetch_defines.svh"

module fetch_stage (
    input  logic                    CLK,
    input  logic                    nRST,
    output logic                    rd_en,
    output fetch_pkg::word_t        rd_addr,
    output logic                    rd_tag,
    input  logic                    rd_valid,
    input  fetch_pkg::word_t        rd_data,
    input  logic                    rd_tag_out,
    output logic                    push,
    output fetch_pkg::fetch_entry_t push_entry,
    input  logic                    credit_return,
    input  logic                    redirect_valid,
    input  fetch_pkg::word_t        redirect_pc
);
    localparam int LAT   = `IMEM_LATENCY;
    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int CW    = $clog2(DEPTH + 1);

    fetch_pkg::word_t pc;
    logic             epoch;
    logic [CW-1:0]    credits;
    logic             issue;
    logic             misaligned;

    // PC and fault of each read in flight
    // Same depth as the memory pipe so they line up with rd_valid
    fetch_pkg::word_t pc_pipe    [LAT];
    logic             fault_pipe [LAT];

    logic             resp_fault;

    // Need a reserved queue slot to issue
    // Quiet in reset, the load port has the memory alone then
    // Redirect cycle issues nothing, old epoch would only be dropped
    assign issue = nRST && (credits != '0) && !redirect_valid;

    // Low PC bits nonzero means misaligned fetch
    assign misaligned = (pc[1:0] != 2'b00);

    // Memory sees the word address only
    assign rd_en   = issue;
    assign rd_addr = {pc[31:2], 2'b00};
    assign rd_tag  = epoch;

    // PC register and epoch
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc    <= `FETCH_RESET_PC;
            epoch <= 1'b0;
        end else if (redirect_valid) begin
            pc    <= redirect_pc;
            // Reads still in flight now carry a stale tag
            epoch <= ~epoch;
        end else if (issue) begin
            pc <= pc + 32'd4;
        end
    end

    // Credit counter
    // Spend on issue, refill on pop
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            credits <= CW'(DEPTH);
        end else if (redirect_valid) begin
            // Queue empties at the same edge
            credits <= CW'(DEPTH);
        end else begin
            credits <= credits - CW'(issue) + CW'(credit_return);
        end
    end

    // Side pipe beside the memory read
    always_ff @(posedge CLK) begin
        pc_pipe[0]    <= pc;
        fault_pipe[0] <= misaligned;
        for (int i = 1; i < LAT; i++) begin
            pc_pipe[i]    <= pc_pipe[i-1];
            fault_pipe[i] <= fault_pipe[i-1];
        end
    end

    assign resp_fault = fault_pipe[LAT-1];

    // Only current-epoch responses reach the queue
    assign push = rd_valid && (rd_tag_out == epoch);

    assign push_entry.pc    = pc_pipe[LAT-1];
    // Squash to zero on a fault
    assign push_entry.instr = resp_fault ? '0 : rd_data;
    assign push_entry.fault = resp_fault;

    // Credits cannot outgrow the queue
    a_credit_bound: assert property (
        @(posedge CLK) disable iff (!nRST) credits <= CW'(DEPTH))
        else $error("fetch_stage: credit counter above queue depth");

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/100ps

`include "fetch_defines.svh"

module fetch_top (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             load_en,
    input  fetch_pkg::word_t load_addr,
    input  fetch_pkg::word_t load_data,
    input  logic             stall,
    input  logic             trap_valid,
    input  fetch_pkg::word_t trap_pc,
    output logic             retire_valid,
    output fetch_pkg::word_t retire_pc,
    output fetch_pkg::word_t retire_instr,
    output logic             retire_fault
);
    // Memory link
    logic             rd_en;
    fetch_pkg::word_t rd_addr;
    logic             rd_tag;
    logic             rd_valid;
    fetch_pkg::word_t rd_data;
    logic             rd_tag_out;

    // Fetch to queue, credits back
    logic                    push;
    fetch_pkg::fetch_entry_t push_entry;
    logic                    credit_return;

    // Queue head to decode
    logic                    head_valid;
    fetch_pkg::fetch_entry_t head_entry;
    logic                    pop;

    // Redirect also flushes the queue
    logic             redirect_valid;
    fetch_pkg::word_t redirect_pc;

    instr_mem imem (
        .CLK        (CLK),
        .nRST       (nRST),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_tag     (rd_tag),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .rd_tag_out (rd_tag_out)
    );

    fetch_stage fetch (
        .CLK            (CLK),
        .nRST           (nRST),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .rd_tag         (rd_tag),
        .rd_valid       (rd_valid),
        .rd_data        (rd_data),
        .rd_tag_out     (rd_tag_out),
        .push           (push),
        .push_entry     (push_entry),
        .credit_return  (credit_return),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    fetch_queue #(
        .entry_t (fetch_pkg::fetch_entry_t),
        .DEPTH   (`FETCH_QUEUE_DEPTH)
    ) queue (
        .CLK           (CLK),
        .nRST          (nRST),
        .push          (push),
        .push_entry    (push_entry),
        .flush         (redirect_valid),
        .head_valid    (head_valid),
        .head_entry    (head_entry),
        .pop           (pop),
        .credit_return (credit_return)
    );

    decode_stage decode (
        .CLK            (CLK),
        .nRST           (nRST),
        .head_valid     (head_valid),
        .head_entry     (head_entry),
        .pop            (pop),
        .stall          (stall),
        .trap_valid     (trap_valid),
        .trap_pc        (trap_pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_instr   (retire_instr),
        .retire_fault   (retire_fault)
    );

endmodule

/* hw/instr_mem.sv */
`timescale 1ns/100ps

`include "fetch_defines.svh"

module instr_mem (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             load_en,
    input  fetch_pkg::word_t load_addr,
    input  fetch_pkg::word_t load_data,
    input  logic             rd_en,
    input  fetch_pkg::word_t rd_addr,
    input  logic             rd_tag,
    output logic             rd_valid,
    output fetch_pkg::word_t rd_data,
    output logic             rd_tag_out
);
    // Word index width and read pipeline depth
    localparam int AW  = $clog2(`IMEM_WORDS);
    localparam int LAT = `IMEM_LATENCY;

    fetch_pkg::word_t mem [`IMEM_WORDS];

    // One slot per cycle of latency
    logic             valid_q [LAT];
    logic             tag_q   [LAT];
    fetch_pkg::word_t data_q  [LAT];

    logic [AW-1:0] load_idx;
    logic [AW-1:0] rd_idx;

    // Byte address to word index, upper bits ignored
    assign load_idx = load_addr[AW+1:2];
    assign rd_idx   = rd_addr[AW+1:2];

    // Load port
    always_ff @(posedge CLK) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end
    end

    // Valid and epoch tag travel down the pipe
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < LAT; i++) begin
                valid_q[i] <= 1'b0;
                tag_q[i]   <= 1'b0;
            end
        end else begin
            valid_q[0] <= rd_en;
            tag_q[0]   <= rd_tag;
            for (int i = 1; i < LAT; i++) begin
                valid_q[i] <= valid_q[i-1];
                tag_q[i]   <= tag_q[i-1];
            end
        end
    end

    // Array read in first stage, then plain delay
    always_ff @(posedge CLK) begin
        if (rd_en) begin
            data_q[0] <= mem[rd_idx];
        end
        for (int i = 1; i < LAT; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign rd_valid   = valid_q[LAT-1];
    assign rd_tag_out = tag_q[LAT-1];
    assign rd_data    = data_q[LAT-1];

    // Loading happens only while fetch is quiet
    a_no_load_during_read: assert property (
        @(posedge CLK) disable iff (!nRST) !(load_en && rd_en))
        else $error("instr_mem: load and read in the same cycle");

endmodule

/* vlog.f */
+incdir+hw
hw/fetch_pkg.sv
hw/instr_mem.sv
hw/fetch_stage.sv
hw/fetch_queue.sv
hw/decode_stage.sv
hw/fetch_top.sv
bench/fetch_tb.sv
